// File: verification/vdpTestdata.txt
# T name | C wordAddr w0 w1 w3 w4 w5 w6 | X colour count fbAddr... | G start, wait for end
# S pixels then ENDR stop | R regOffset value | I irqN level
T reset
I 1
R 10 0
R 12 0
R 14 0
T lines
C 00 00060000 00001111 00020001 00040001 0 0
C 08 00060000 00002222 00050003 00050001 0 0
C 10 00060000 00003333 00000000 00030001 0 0
C 18 00060000 00004444 00010000 00000002 0 0
C 20 80000000 0 0 0 0 0
X 1111 3 202 203 204
X 2222 3 605 405 205
X 3333 4 000 001 002 203
X 4444 3 001 201 400
G
T polyline
C 00 00050000 00005555 00000000 00020000 00020002 00000002
C 08 80000000 0 0 0 0 0
X 5555 12 000 001 002 002 202 402 402 401 400 400 200 000
G
T flow
C 00 1006000C 000000A1 00010000 00010000 0 0
C 18 20060014 000000A1 00020000 00020000 0 0
C 28 70060000 000000A1 00090000 00090000 0 0
C 20 10060004 000000A1 00030000 00030000 0 0
C 08 80000000 0 0 0 0 0
X 00A1 3 001 002 003
G
I 0
R 12 0010
R 14 0004
T stop
C 00 00060000 000000D1 00000005 00C80005 0 0
X 00D1 4 A00 A01 A02 A03
S 3
R 10 0001
I 1
T clip
C 00 00090000 0 0 0 000400FF 0
C 08 00080000 0 00010000 0 000300FF 0
C 10 000A0000 0 00010001 0 0 0
C 18 00060000 040000C1 00000000 00040000 0 0
C 20 00060000 000000C2 00000002 00040002 0 0
C 28 80000000 0 0 0 0 0
X 00C1 3 201 202 203
X 00C2 4 601 602 603 604
G

// File: sources.f
hdl/vdpRegPkg.sv
hdl/vdpCmdPkg.sv
hdl/vdpRegs.sv
hdl/vdpCmdFetch.sv
hdl/vdpCmdSeq.sv
hdl/vdpLineDraw.sv
hdl/vdpTop.sv
verification/vdpTb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench, then look for the fail message in the log
verilator --binary --timing --assert -f sources.f --top-module vdpTb -o vdpSim \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/vdpSim > sim.log 2>&1 || true
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0

// File: verification/vdpTb.sv
module vdpTb import vdpRegPkg::*, vdpCmdPkg::*; ();
	localparam int FbXBits = 9;
	localparam int FbYBits = 8;

	logic                       CLK;
	logic                       RST_N;
	RegReq_t                    regReq = '0;
	logic [15:0]                regRdata;
	VramReq_t                   vramReq;
	VramRsp_t                   vramRsp = '0;
	logic [FbXBits+FbYBits-1:0] fbAddr;
	logic [15:0]                fbData;
	logic                       fbWe;
	logic                       irqN;

	logic [31:0]                       vram [0:255];  // 32-bit words
	logic [31:0]                       rdQ [$];       // Accepted reads waiting for drdy
	logic [FbXBits+FbYBits+15:0]       seen [$];
	logic [FbXBits+FbYBits+15:0]       expWr [$];
	logic [8*16-1:0]                   testName = "init";
	int                                budget = 0;

	vdpTop #(
		.FbXBits(FbXBits),
		.FbYBits(FbYBits)
	) UUT (.CLK, .RST_N, .regReq, .regRdata, .vramReq, .vramRsp, .fbAddr, .fbData,
		.fbWe, .irqN);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// VRAM with random address stalls, replies in order
	always @(posedge CLK) begin
		if (rdQ.size() > 0) begin
			vramRsp.drdy <= 1'b1;
			vramRsp.data <= rdQ.pop_front();
		end else begin
			vramRsp.drdy <= 1'b0;
		end
		if (vramReq.rd && vramRsp.ardy)
			rdQ.push_back(vram[vramReq.addr[8:1]]);
		vramRsp.ardy <= $urandom_range(2, 0) != 0;
	end

	always @(negedge CLK)
		if (RST_N && fbWe)
			seen.push_back({fbAddr, fbData});

	task automatic check(input logic [63:0] expVal, input logic [63:0] actVal);
		if (expVal !== actVal) begin
			$display("[FAIL] %0s: expected %0h, actual %0h", testName, expVal, actVal);
			$display("CHECKS FAILED");
			$fatal(1, "Mismatch in test %0s", testName);
		end
	endtask

	task automatic writeReg(input RegAddr_t ofs, input logic [15:0] data);
		@(posedge CLK);
		regReq <= '{write: 1'b1, read: 1'b0, addr: ofs, wdata: data};
		@(posedge CLK);
		regReq.write <= 1'b0;
	endtask

	task automatic readReg(input RegAddr_t ofs, output logic [15:0] data);
		@(posedge CLK);
		regReq <= '{write: 1'b0, read: 1'b1, addr: ofs, wdata: 16'd0};
		@(posedge CLK);
		regReq.read <= 1'b0;
		@(negedge CLK);
		data = regRdata;
	endtask

	// Start the list, CEF clears one cycle after drawStart
	task automatic startList;
		writeReg(PtmrOfs, 16'd1);
		@(posedge CLK);
		@(negedge CLK);
		check(64'd1, 64'(irqN));
	endtask

	task automatic comparePixels;
		check(64'(expWr.size()), 64'(seen.size()));
		foreach (expWr[i])
			check(64'(expWr[i]), 64'(seen[i]));
		expWr.delete();
		seen.delete();
	endtask

	// Work budget for the watchdog from tables and pixels in the data file
	task automatic countWork;
		int fd;
		int n;
		int pix;
		int tables;
		logic [7:0] tok;
		logic [15:0] col;
		logic [8*128-1:0] rest;
		pix = 0;
		tables = 0;
		fd = $fopen("verification/vdpTestdata.txt", "r");
		while ($fscanf(fd, " %c", tok) == 1) begin
			if (tok == "C")
				tables++;
			if (tok == "X") begin
				void'($fscanf(fd, "%h %d", col, n));
				pix += n;
			end
			void'($fgets(rest, fd));
		end
		$fclose(fd);
		budget = (40 * pix + 30 * tables + 400) * 20;
	endtask

	initial begin
		wait (budget > 0);
		#(budget);
		$display("Timeout: the DUT did not finish the tests in time");
		$display("CHECKS FAILED");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		int fd;
		int n;
		int pixCnt;
		logic [7:0] tok;
		logic [7:0] a;
		logic [31:0] w [0:5];
		logic [15:0] col;
		logic [16:0] fa;
		RegAddr_t ofs;
		logic [15:0] val;
		logic [15:0] rdVal;
		logic bitVal;
		logic [8*128-1:0] rest;
		void'($urandom(32'hdc32_fc4f));
		RST_N = 1'b0;
		countWork();
		repeat (2) @(posedge CLK);
		RST_N <= 1'b1;
		fd = $fopen("verification/vdpTestdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open verification/vdpTestdata.txt");
			$display("CHECKS FAILED");
			$fatal(1, "No test data");
		end
		while ($fscanf(fd, " %c", tok) == 1) begin
			if (tok == "#") begin
				void'($fgets(rest, fd));
			end else if (tok == "T") begin
				void'($fscanf(fd, "%s", testName));
				foreach (vram[i])
					vram[i] = '0;
			end else if (tok == "C") begin  // Words 2 and 7 stay 0
				void'($fscanf(fd, "%h %h %h %h %h %h %h", a, w[0], w[1], w[2], w[3], w[4], w[5]));
				vram[a] = w[0];
				vram[a + 8'd1] = w[1];
				vram[a + 8'd3] = w[2];
				vram[a + 8'd4] = w[3];
				vram[a + 8'd5] = w[4];
				vram[a + 8'd6] = w[5];
			end else if (tok == "X") begin
				void'($fscanf(fd, "%h %d", col, n));
				repeat (n) begin
					void'($fscanf(fd, "%h", fa));
					expWr.push_back({fa, col});
				end
			end else if (tok == "G") begin
				startList();
				while (irqN)
					@(negedge CLK);
				comparePixels();
			end else if (tok == "S") begin
				void'($fscanf(fd, "%d", n));
				startList();
				pixCnt = 0;
				while (pixCnt < n) begin
					@(negedge CLK);
					if (fbWe)
						pixCnt++;
				end
				writeReg(EndrOfs, 16'h0002);
				repeat (20) @(posedge CLK);
				comparePixels();
			end else if (tok == "R") begin
				void'($fscanf(fd, "%h %h", ofs, val));
				readReg(ofs, rdVal);
				check(64'(val), 64'(rdVal));
			end else if (tok == "I") begin
				void'($fscanf(fd, "%d", bitVal));
				check(64'(bitVal), 64'(irqN));
			end
		end
		$fclose(fd);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: hdl/vdpTop.sv
module vdpTop import vdpRegPkg::*, vdpCmdPkg::*; #(
	parameter int FbXBits = 9,
	parameter int FbYBits = 8
) (
	input  logic                       CLK,
	input  logic                       RST_N,
	input  RegReq_t                    regReq,
	output logic [15:0]                regRdata,
	output VramReq_t                   vramReq,
	input  VramRsp_t                   vramRsp,
	output logic [FbXBits+FbYBits-1:0] fbAddr,
	output logic [15:0]                fbData,
	output logic                       fbWe,
	output logic                       irqN
);
	logic        drawStart;
	logic        drawStop;
	logic        cmdDone;
	logic [15:0] curAddr;
	logic        fetchGo;
	VramAddr_t   fetchAddr;
	CmdTbl_t     cmdTbl;
	logic        tableValid;
	logic        lineGo;
	logic        lineDone;
	Vertex_t     lineA;
	Vertex_t     lineB;
	logic [15:0] colour;
	Vertex_t     offset;
	Clip_t       sysClip;
	Clip_t       usrClip;
	logic        usrClipEn;

	vdpRegs regs (.CLK, .RST_N, .regReq, .regRdata, .drawStart, .drawStop,
		.cmdDone, .curAddr, .irqN);

	vdpCmdFetch fetch (.CLK, .RST_N, .fetchGo, .fetchAddr, .vramReq, .vramRsp,
		.cmdTbl, .tableValid);

	vdpCmdSeq seq (.CLK, .RST_N, .drawStart, .drawStop, .cmdTbl, .tableValid,
		.fetchGo, .fetchAddr, .curAddr, .cmdDone, .lineGo, .lineA, .lineB,
		.colour, .offset, .sysClip, .usrClip, .usrClipEn, .lineDone);

	vdpLineDraw #(
		.FbXBits(FbXBits),
		.FbYBits(FbYBits)
	) draw (.CLK, .RST_N, .drawStop, .lineGo, .lineA, .lineB, .colour, .offset,
		.sysClip, .usrClip, .usrClipEn, .lineDone, .fbAddr, .fbData, .fbWe);

endmodule

// File: hdl/vdpLineDraw.sv
module vdpLineDraw import vdpCmdPkg::*; #(
	parameter int FbXBits = 9,
	parameter int FbYBits = 8
) (
	input  logic                       CLK,
	input  logic                       RST_N,
	input  logic                       drawStop,
	input  logic                       lineGo,
	input  Vertex_t                    lineA,
	input  Vertex_t                    lineB,
	input  logic [15:0]                colour,
	input  Vertex_t                    offset,
	input  Clip_t                      sysClip,
	input  Clip_t                      usrClip,
	input  logic                       usrClipEn,
	output logic                       lineDone,
	output logic [FbXBits+FbYBits-1:0] fbAddr,
	output logic [15:0]                fbData,
	output logic                       fbWe
);
	logic               active;
	Vertex_t            pos;
	Vertex_t            tgt;
	logic               dirX;  // Negative step
	logic               dirY;
	logic               yMajor;
	logic [10:0]        lenX;
	logic [10:0]        lenY;
	logic [11:0]        err;
	logic signed [11:0] dx;
	logic signed [11:0] dy;
	logic [10:0]        absX;
	logic [10:0]        absY;
	logic [10:0]        majorLen;
	logic [10:0]        minorLen;
	logic [11:0]        errSum;
	logic               minorStep;
	logic               lastPix;
	logic signed [11:0] drawX;
	logic signed [11:0] drawY;
	logic               sysIn;
	logic               usrIn;

	assign dx = lineB.x - lineA.x;
	assign dy = lineB.y - lineA.y;
	assign absX = dx[11] ? 11'(-dx) : 11'(dx);
	assign absY = dy[11] ? 11'(-dy) : 11'(dy);

	assign majorLen = yMajor ? lenY : lenX;
	assign minorLen = yMajor ? lenX : lenY;
	assign errSum = err + {1'b0, minorLen};
	assign minorStep = errSum >= {1'b0, majorLen};
	assign lastPix = yMajor ? pos.y == tgt.y : pos.x == tgt.x;

	assign drawX = pos.x + offset.x;
	assign drawY = pos.y + offset.y;
	assign sysIn = !drawX[11] && drawX[10:0] <= {1'b0, sysClip.x2} &&
		!drawY[11] && drawY[10:0] <= {1'b0, sysClip.y2};
	assign usrIn = drawX[10:0] >= {1'b0, usrClip.x1} && drawX[10:0] <= {1'b0, usrClip.x2} &&
		drawY[10:0] >= {1'b0, usrClip.y1} && drawY[10:0] <= {1'b0, usrClip.y2};

	assign fbWe = active && !drawStop && sysIn && (usrIn || !usrClipEn);
	assign fbAddr = {drawY[FbYBits-1:0], drawX[FbXBits-1:0]};
	assign fbData = colour;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			active <= 1'b0;
			lineDone <= 1'b0;
			pos <= '0;
			tgt <= '0;
			dirX <= 1'b0;
			dirY <= 1'b0;
			yMajor <= 1'b0;
			lenX <= '0;
			lenY <= '0;
			err <= '0;
		end else begin
			lineDone <= 1'b0;
			if (drawStop) begin
				active <= 1'b0;
			end else if (lineGo) begin
				active <= 1'b1;
				pos <= lineA;
				tgt <= lineB;
				dirX <= dx[11];
				dirY <= dy[11];
				lenX <= absX;
				lenY <= absY;
				yMajor <= absY > absX;  // Ties step along X
				err <= '0;
			end else if (active) begin
				if (lastPix) begin
					active <= 1'b0;
					lineDone <= 1'b1;
				end
				err <= minorStep ? errSum - {1'b0, majorLen} : errSum;
				if (!yMajor || minorStep)
					pos.x <= dirX ? pos.x - 11'sd1 : pos.x + 11'sd1;
				if (yMajor || minorStep)
					pos.y <= dirY ? pos.y - 11'sd1 : pos.y + 11'sd1;
			end
		end
	end

	// Error term stays below the major length
	assert property (@(posedge CLK) disable iff (!RST_N)
		active && majorLen != '0 |-> err < {1'b0, majorLen});

endmodule

// File: hdl/vdpCmdSeq.sv
module vdpCmdSeq import vdpCmdPkg::*; (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic        drawStart,
	input  logic        drawStop,
	input  CmdTbl_t     cmdTbl,
	input  logic        tableValid,
	output logic        fetchGo,
	output VramAddr_t   fetchAddr,
	output logic [15:0] curAddr,
	output logic        cmdDone,
	output logic        lineGo,
	output Vertex_t     lineA,
	output Vertex_t     lineB,
	output logic [15:0] colour,
	output Vertex_t     offset,
	output Clip_t       sysClip,
	output Clip_t       usrClip,
	output logic        usrClipEn,
	input  logic        lineDone
);
	typedef enum logic [2:0] {SeqIdle, SeqFetch, SeqExec, SeqLine, SeqNext} SeqState_t;

	SeqState_t  state;
	VramAddr_t  retAddr;   // Saved by call
	VramAddr_t  nextAddr;
	logic [1:0] edgeIdx;   // Polyline edge, 3 is the last
	Vertex_t    nextVert;

	assign nextAddr = fetchAddr + 18'd16;

	always_comb begin
		case (edgeIdx)
			2'd0: nextVert = cmdTbl.c;
			2'd1: nextVert = cmdTbl.d;
			default: nextVert = cmdTbl.a;  // Closing edge D to A
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= SeqIdle;
			fetchGo <= 1'b0;
			fetchAddr <= '0;
			retAddr <= '0;
			curAddr <= '0;
			cmdDone <= 1'b0;
			lineGo <= 1'b0;
			lineA <= '0;
			lineB <= '0;
			colour <= '0;
			edgeIdx <= '0;
			offset <= '0;
			sysClip <= {10'd0, 10'd0, 10'd319, 10'd255};
			usrClip <= '0;
			usrClipEn <= 1'b0;
		end else begin
			fetchGo <= 1'b0;
			lineGo <= 1'b0;
			cmdDone <= 1'b0;
			if (drawStop) begin
				state <= SeqIdle;
			end else if (drawStart) begin
				fetchAddr <= '0;
				fetchGo <= 1'b1;
				state <= SeqFetch;
			end else begin
				case (state)
					SeqFetch: if (tableValid) begin
						curAddr <= fetchAddr[17:2];
						state <= SeqExec;
					end
					SeqExec: begin
						state <= SeqNext;
						if (!cmdTbl.ctrl.endBit && !cmdTbl.ctrl.jp[2]) begin
							case (cmdTbl.ctrl.comm)
								CmdLine, CmdPolyline: begin
									lineA <= cmdTbl.a;
									lineB <= cmdTbl.b;
									colour <= cmdTbl.colr;
									usrClipEn <= cmdTbl.pmod.clip;
									edgeIdx <= cmdTbl.ctrl.comm == CmdLine ? 2'd3 : 2'd0;
									lineGo <= 1'b1;
									state <= SeqLine;
								end
								CmdUsrClip: usrClip <= {cmdTbl.a.x[9:0], cmdTbl.a.y[9:0],
									cmdTbl.c.x[9:0], cmdTbl.c.y[9:0]};
								CmdSysClip: sysClip <= {20'd0, cmdTbl.c.x[9:0], cmdTbl.c.y[9:0]};
								CmdLocal: offset <= cmdTbl.a;
								default: ;
							endcase
						end
					end
					SeqLine: if (lineDone) begin
						if (edgeIdx == 2'd3) begin
							state <= SeqNext;
						end else begin
							edgeIdx <= edgeIdx + 2'd1;
							lineA <= lineB;
							lineB <= nextVert;
							lineGo <= 1'b1;
						end
					end
					SeqNext: begin
						if (cmdTbl.ctrl.endBit) begin
							cmdDone <= 1'b1;
							state <= SeqIdle;
						end else begin
							case (cmdTbl.ctrl.jp[1:0])
								2'd0: fetchAddr <= nextAddr;
								2'd1: fetchAddr <= {cmdTbl.link, 2'b00};
								2'd2: begin
									fetchAddr <= {cmdTbl.link, 2'b00};
									retAddr <= nextAddr;
								end
								default: fetchAddr <= retAddr;
							endcase
							fetchGo <= 1'b1;
							state <= SeqFetch;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// File: hdl/vdpCmdFetch.sv
module vdpCmdFetch import vdpCmdPkg::*; (
	input  logic      CLK,
	input  logic      RST_N,
	input  logic      fetchGo,
	input  VramAddr_t fetchAddr,
	output VramReq_t  vramReq,
	input  VramRsp_t  vramRsp,
	output CmdTbl_t   cmdTbl,
	output logic      tableValid
);
	localparam int CntBits = $clog2(CmdWords);
	localparam logic [CntBits-1:0] LastWord = CntBits'(CmdWords - 1);

	logic [CntBits-1:0] reqCnt;  // Accepted reads
	logic [CntBits-1:0] rspCnt;  // Returned words

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			vramReq <= '0;
			reqCnt <= '0;
			rspCnt <= '0;
			tableValid <= 1'b0;
		end else begin
			tableValid <= 1'b0;
			if (fetchGo) begin
				vramReq.rd <= 1'b1;
				vramReq.addr <= fetchAddr;
				reqCnt <= '0;
				rspCnt <= '0;
			end else if (vramReq.rd && vramRsp.ardy) begin
				vramReq.addr <= vramReq.addr + 18'd2;
				reqCnt <= reqCnt + 1'b1;
				if (reqCnt == LastWord)
					vramReq.rd <= 1'b0;
			end
			if (vramRsp.drdy) begin
				rspCnt <= rspCnt + 1'b1;
				tableValid <= rspCnt == LastWord;
			end
		end
	end

	// Words 2 and 7 carry texture and gouraud data, dropped
	always_ff @(posedge CLK) begin
		if (vramRsp.drdy) begin
			case (rspCnt)
				0: {cmdTbl.ctrl, cmdTbl.link} <= vramRsp.data;
				1: {cmdTbl.pmod, cmdTbl.colr} <= vramRsp.data;
				3: cmdTbl.a <= {vramRsp.data[26:16], vramRsp.data[10:0]};
				4: cmdTbl.b <= {vramRsp.data[26:16], vramRsp.data[10:0]};
				5: cmdTbl.c <= {vramRsp.data[26:16], vramRsp.data[10:0]};
				6: cmdTbl.d <= {vramRsp.data[26:16], vramRsp.data[10:0]};
				default: ;
			endcase
		end
	end

	assert property (@(posedge CLK) disable iff (!RST_N)
		vramReq.rd && !vramRsp.ardy |=> vramReq.rd && $stable(vramReq.addr));

endmodule

// File: hdl/vdpRegs.sv
module vdpRegs import vdpRegPkg::*; (
	input  logic        CLK,
	input  logic        RST_N,
	input  RegReq_t     regReq,
	output logic [15:0] regRdata,
	output logic        drawStart,
	output logic        drawStop,
	input  logic        cmdDone,
	input  logic [15:0] curAddr,
	output logic        irqN
);
	logic [1:0]  ptm;
	Edsr_t       edsr;
	logic [15:0] lopr;
	logic [15:0] copr;
	logic [15:0] lastAddr;  // Previous curAddr, for change detect

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ptm <= '0;
			edsr <= '0;
			lopr <= '0;
			copr <= '0;
			lastAddr <= '0;
			drawStart <= 1'b0;
			drawStop <= 1'b0;
			regRdata <= '0;
		end else begin
			drawStart <= regReq.write && regReq.addr == PtmrOfs && regReq.wdata[1:0] == 2'b01;
			drawStop <= regReq.write && regReq.addr == EndrOfs && regReq.wdata[1];
			if (regReq.write && regReq.addr == PtmrOfs)
				ptm <= regReq.wdata[1:0];

			if (drawStart) begin
				edsr.bef <= edsr.cef;
				edsr.cef <= 1'b0;
			end else if (cmdDone) begin
				edsr.cef <= 1'b1;
			end

			// A new table was fetched
			lastAddr <= curAddr;
			if (curAddr != lastAddr) begin
				lopr <= copr;
				copr <= curAddr;
			end

			if (regReq.read) begin
				case (regReq.addr)
					PtmrOfs: regRdata <= {14'd0, ptm};
					EdsrOfs: regRdata <= {14'd0, edsr};
					LoprOfs: regRdata <= lopr;
					CoprOfs: regRdata <= copr;
					default: regRdata <= '0;
				endcase
			end
		end
	end

	assign irqN = ~edsr.cef;

	// One list end per start
	assert property (@(posedge CLK) disable iff (!RST_N) cmdDone |-> !edsr.cef);

endmodule

// File: hdl/vdpCmdPkg.sv
package vdpCmdPkg;

	typedef logic signed [10:0] Coord_t;
	typedef logic [17:0] VramAddr_t;  // Halfword address

	typedef struct packed {
		Coord_t x;
		Coord_t y;
	} Vertex_t;

	typedef struct packed {
		logic [9:0] x1;
		logic [9:0] y1;
		logic [9:0] x2;
		logic [9:0] y2;
	} Clip_t;

	typedef struct packed {
		logic       endBit;
		logic [2:0] jp;    // Bit 2 skip, 1:0 next/jump/call/return
		logic [7:0] rsvd;  // Zoom point and direction, no use here
		logic [3:0] comm;
	} CmdCtrl_t;

	typedef struct packed {
		logic [4:0] rsvdHi;
		logic       clip;  // User clip enable
		logic [9:0] rsvdLo;
	} CmdPmod_t;

	typedef struct packed {
		CmdCtrl_t    ctrl;
		logic [15:0] link;
		CmdPmod_t    pmod;
		logic [15:0] colr;
		Vertex_t     a;
		Vertex_t     b;
		Vertex_t     c;
		Vertex_t     d;
	} CmdTbl_t;

	typedef struct packed {
		logic      rd;
		VramAddr_t addr;
	} VramReq_t;

	typedef struct packed {
		logic        ardy;
		logic        drdy;
		logic [31:0] data;
	} VramRsp_t;

	localparam logic [3:0] CmdPolyline = 4'h5;
	localparam logic [3:0] CmdLine     = 4'h6;
	localparam logic [3:0] CmdUsrClip  = 4'h8;
	localparam logic [3:0] CmdSysClip  = 4'h9;
	localparam logic [3:0] CmdLocal    = 4'hA;

	localparam int CmdWords = 8;  // 32-bit words per table

endpackage

// File: hdl/vdpRegPkg.sv
package vdpRegPkg;

	// Byte offset of a 16-bit register
	typedef logic [4:0] RegAddr_t;

	localparam RegAddr_t PtmrOfs = 5'h04; // Plot trigger
	localparam RegAddr_t EndrOfs = 5'h0C; // Forced draw end
	localparam RegAddr_t EdsrOfs = 5'h10;
	localparam RegAddr_t LoprOfs = 5'h12; // Last table address
	localparam RegAddr_t CoprOfs = 5'h14; // Current table address

	typedef struct packed {
		logic cef;  // Current frame ended
		logic bef;  // Previous frame ended
	} Edsr_t;

	typedef struct packed {
		logic        write;
		logic        read;
		RegAddr_t    addr;
		logic [15:0] wdata;
	} RegReq_t;

endpackage
